//--- Makefile
# Verilator flow for the element add subsystem
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_add_accel
RTL_TOP   ?= add_accel_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+hdl
hdl/cfg_pkg.sv
hdl/glb_pkg.sv
hdl/step_counter.sv
hdl/chan_add.sv
hdl/glb_buffer.sv
hdl/cfg_issuer.sv
hdl/add_accel_top.sv
dv/tb_add_accel.sv

//--- dv/tb_add_accel.sv
// Testbench for the element add subsystem
// Loads operands over the host port, runs add jobs, reads sums back
// and compares them with a lane-wise model kept on shadow banks
`timescale 1ns/1ps
`default_nettype none

`include "eltwise_params.svh"

module tb_add_accel;

    // Jobs of 8, 2, 64, a cut-short 300 and 16 words; bank 0 shared at two
    // cycles per word, host reads two cycles each, generous stall margin
    localparam int MAX_CYCLES = 4000;
    localparam int DONE_WAIT  = 1500;

    logic               clk;
    logic               rst_n;
    logic               start;
    cfg_pkg::add_cfg_t  cfg;
    logic               busy;
    logic               done;
    logic               host_vld;
    glb_pkg::host_req_t host_req;
    logic               host_rd_vld;
    glb_pkg::glb_word_t host_rd;

    // Shadow copies of both banks
    glb_pkg::glb_word_t shadow0 [`GLB_DEPTH];
    glb_pkg::glb_word_t shadow1 [`GLB_DEPTH];
    logic [31:0]        lfsr_q;
    int                 cycle_cnt = 0;
    int                 err_cnt;
    int                 fail_tests;
    int                 test_cnt;
    int                 done_cnt;
    logic               job_open;

    add_accel_top i_add_accel_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .cfg_i         (cfg),
        .busy_o        (busy),
        .done_o        (done),
        .host_vld_i    (host_vld),
        .host_i        (host_req),
        .host_rd_vld_o (host_rd_vld),
        .host_rd_o     (host_rd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // ======================================================================
    // Job tracking and handshake assertions
    // ======================================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_open <= 1'b0;
            done_cnt <= 0;
        end else begin
            if (start) job_open <= 1'b1;
            else if (done) job_open <= 1'b0;
            if (done) done_cnt <= done_cnt + 1;
        end
    end

    a_done_after_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> job_open
    ) else begin
        err_cnt++;
        $display("Error: done pulse seen with no job started");
    end

    // Busy from the cycle after start up to done
    a_busy_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        job_open && !done |-> busy
    ) else begin
        err_cnt++;
        $display("Error: busy dropped while a job was open");
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic rand_word(output glb_pkg::glb_word_t w);
        logic [`ADD_LANES*`ADD_LANE_W-1:0] r;
        r = '0;
        for (int i = 0; i < `ADD_LANES*`ADD_LANE_W; i++) begin
            r = {r[`ADD_LANES*`ADD_LANE_W-2:0], lfsr_q[0]};
            lfsr_q = galois_step(lfsr_q);
        end
        w = r;
    endtask

    // Wrapping lane sum, carry out of each lane dropped
    function automatic glb_pkg::glb_word_t lane_add(input glb_pkg::glb_word_t a,
                                                    input glb_pkg::glb_word_t b);
        glb_pkg::glb_word_t s;
        logic [`ADD_LANE_W:0] full;
        for (int l = 0; l < `ADD_LANES; l++) begin
            full = {1'b0, a[l]} + {1'b0, b[l]};
            s[l] = full[`ADD_LANE_W-1:0];
        end
        return s;
    endfunction

    function automatic cfg_pkg::add_cfg_t mk_cfg(input int a, input int b,
                                                 input int s, input int n);
        cfg_pkg::add_cfg_t c;
        c.a_base   = `ADD_ADDR_W'(a);
        c.b_base   = `ADD_ADDR_W'(b);
        c.sum_base = `ADD_ADDR_W'(s);
        c.count    = `ADD_ADDR_W'(n);
        return c;
    endfunction

    task automatic host_write(input logic bank, input int addr,
                              input glb_pkg::glb_word_t data);
        @(posedge clk);
        host_vld <= 1'b1;
        host_req <= '{bank: bank, wr: 1'b1, addr: `ADD_ADDR_W'(addr), data: data};
        if (bank) shadow1[addr] = data;
        else shadow0[addr] = data;
    endtask

    task automatic host_release();
        @(posedge clk);
        host_vld <= 1'b0;
    endtask

    // Read data arrives one cycle after the request
    task automatic host_read(input logic bank, input int addr,
                             output glb_pkg::glb_word_t data);
        int n;
        n = 0;
        @(posedge clk);
        host_vld <= 1'b1;
        host_req <= '{bank: bank, wr: 1'b0, addr: `ADD_ADDR_W'(addr), data: '0};
        @(posedge clk);
        host_vld <= 1'b0;
        @(negedge clk);
        while (!host_rd_vld && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!host_rd_vld) begin
            err_cnt++;
            $display("Error: host read of bank %0d word %0d returned nothing", bank, addr);
        end
        data = host_rd;
    endtask

    task automatic load_operands(input int a_base, input int b_base, input int n);
        glb_pkg::glb_word_t w;
        for (int i = 0; i < n; i++) begin
            rand_word(w);
            host_write(1'b0, a_base + i, w);
            rand_word(w);
            host_write(1'b1, b_base + i, w);
        end
        host_release();
    endtask

    task automatic start_job(input cfg_pkg::add_cfg_t c);
        @(posedge clk);
        start <= 1'b1;
        cfg   <= c;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < DONE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            err_cnt++;
            $display("Error: %s never raised done", name);
        end
    endtask

    // Expected sums land in the bank 0 shadow
    task automatic model_add(input cfg_pkg::add_cfg_t c);
        for (int i = 0; i < int'(c.count); i++) begin
            shadow0[`ADD_ADDR_W'(c.sum_base + i)] =
                lane_add(shadow0[`ADD_ADDR_W'(c.a_base + i)], shadow1[`ADD_ADDR_W'(c.b_base + i)]);
        end
    endtask

    task automatic check_word(input string name, input glb_pkg::glb_word_t exp,
                              input glb_pkg::glb_word_t act);
        a_word_match: assert (act === exp) else begin
            err_cnt++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_region(input string name, input logic bank,
                                input int base, input int n);
        glb_pkg::glb_word_t act;
        glb_pkg::glb_word_t exp;
        for (int i = 0; i < n; i++) begin
            exp = bank ? shadow1[base + i] : shadow0[base + i];
            host_read(bank, base + i, act);
            check_word(name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err_mark);
        test_cnt++;
        if (err_cnt != err_mark) begin
            fail_tests++;
            $display("[%0d] %s: FAIL, %0d errors", test_cnt, name, err_cnt - err_mark);
        end else begin
            $display("[%0d] %s: ok", test_cnt, name);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int                 err_mark;
        int                 dones;
        cfg_pkg::add_cfg_t  job;
        cfg_pkg::add_cfg_t  long_job;
        glb_pkg::glb_word_t act;
        rst_n      = 1'b0;
        start      = 1'b0;
        cfg        = '0;
        host_vld   = 1'b0;
        host_req   = '0;
        lfsr_q     = 32'h332;
        err_cnt    = 0;
        fail_tests = 0;
        test_cnt   = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs quiet out of reset
        err_mark = err_cnt;
        @(negedge clk);
        a_reset_quiet: assert (!busy && !done && !host_rd_vld) else begin
            err_cnt++;
            $display("Error: busy, done or host read valid high after reset");
        end
        finish_test("reset_quiet", err_mark);

        // Short random job, operands must survive
        err_mark = err_cnt;
        job = mk_cfg(0, 0, 512, 8);
        load_operands(0, 0, 8);
        start_job(job);
        wait_done("add8");
        model_add(job);
        check_region("add8_sum", 1'b0, 512, 8);
        check_region("add8_opa", 1'b0, 0, 8);
        check_region("add8_opb", 1'b1, 0, 8);
        finish_test("add8", err_mark);

        // Lane 1 and lane 3 overflow, lane 2 must not see a carry
        err_mark = err_cnt;
        host_write(1'b0, 20, {16'hFFFF, 16'h0000, 16'hFFFF, 16'h1234});
        host_write(1'b0, 21, {4{16'hFFFF}});
        host_write(1'b1, 20, {16'h0002, 16'h7FFF, 16'h0002, 16'h0001});
        host_write(1'b1, 21, {4{16'hFFFF}});
        host_release();
        job = mk_cfg(20, 20, 40, 2);
        start_job(job);
        wait_done("wrap");
        model_add(job);
        host_read(1'b0, 40, act);
        check_word("wrap_lanes", {16'h0001, 16'h7FFF, 16'h0001, 16'h1235}, act);
        check_region("wrap_model", 1'b0, 40, 2);
        finish_test("wrap", err_mark);

        // Sum writes fight operand A reads for bank 0
        err_mark = err_cnt;
        job = mk_cfg(100, 100, 300, 64);
        load_operands(100, 100, 64);
        start_job(job);
        wait_done("bp64");
        model_add(job);
        check_region("bp64_sum", 1'b0, 300, 64);
        finish_test("bp64", err_mark);

        // Second start cuts the long job short
        err_mark = err_cnt;
        job      = mk_cfg(200, 200, 400, 16);
        long_job = mk_cfg(600, 600, 700, 300);
        load_operands(200, 200, 16);
        dones = done_cnt;
        start_job(long_job);
        repeat (40) @(posedge clk);
        start_job(job);
        wait_done("restart");
        repeat (20) @(negedge clk);
        a_single_done: assert (done_cnt - dones == 1) else begin
            err_cnt++;
            $display("MISMATCH restart_done expected %0d actual %0d", 1, done_cnt - dones);
        end
        model_add(job);
        check_region("restart_sum", 1'b0, 400, 16);
        finish_test("restart", err_mark);

        $display("Tests: %0d run, %0d failing, %0d errors", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/add_accel_top.sv
// Element add subsystem top
// Joins the issuer, the add engine and the two-bank buffer
`timescale 1ns/1ps
`default_nettype none

module add_accel_top (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                start_i,
    input  cfg_pkg::add_cfg_t  cfg_i,
    output logic               busy_o,
    output logic               done_o,
    input  wire                host_vld_i,
    input  glb_pkg::host_req_t host_i,
    output logic               host_rd_vld_o,
    output glb_pkg::glb_word_t host_rd_o
);

    // Issuer to engine
    logic               cfg_vld;
    logic               cfg_rdy;
    cfg_pkg::add_cfg_t  cfg;

    // Engine to buffer
    logic               a_req_vld;
    logic               a_req_rdy;
    glb_pkg::rd_req_t   a_req;
    logic               a_rsp_vld;
    logic               a_rsp_rdy;
    glb_pkg::glb_word_t a_rsp;
    logic               b_req_vld;
    logic               b_req_rdy;
    glb_pkg::rd_req_t   b_req;
    logic               b_rsp_vld;
    logic               b_rsp_rdy;
    glb_pkg::glb_word_t b_rsp;
    logic               wr_vld;
    logic               wr_rdy;
    glb_pkg::wr_req_t   wr;

    cfg_issuer i_cfg_issuer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .cfg_i     (cfg_i),
        .cfg_vld_o (cfg_vld),
        .cfg_rdy_i (cfg_rdy),
        .cfg_o     (cfg),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    chan_add i_chan_add (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_vld_i   (cfg_vld),
        .cfg_rdy_o   (cfg_rdy),
        .cfg_i       (cfg),
        .a_req_vld_o (a_req_vld),
        .a_req_rdy_i (a_req_rdy),
        .a_req_o     (a_req),
        .a_rsp_vld_i (a_rsp_vld),
        .a_rsp_rdy_o (a_rsp_rdy),
        .a_rsp_i     (a_rsp),
        .b_req_vld_o (b_req_vld),
        .b_req_rdy_i (b_req_rdy),
        .b_req_o     (b_req),
        .b_rsp_vld_i (b_rsp_vld),
        .b_rsp_rdy_o (b_rsp_rdy),
        .b_rsp_i     (b_rsp),
        .wr_vld_o    (wr_vld),
        .wr_rdy_i    (wr_rdy),
        .wr_o        (wr)
    );

    glb_buffer i_glb_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .a_req_vld_i   (a_req_vld),
        .a_req_rdy_o   (a_req_rdy),
        .a_req_i       (a_req),
        .a_rsp_vld_o   (a_rsp_vld),
        .a_rsp_rdy_i   (a_rsp_rdy),
        .a_rsp_o       (a_rsp),
        .b_req_vld_i   (b_req_vld),
        .b_req_rdy_o   (b_req_rdy),
        .b_req_i       (b_req),
        .b_rsp_vld_o   (b_rsp_vld),
        .b_rsp_rdy_i   (b_rsp_rdy),
        .b_rsp_o       (b_rsp),
        .wr_vld_i      (wr_vld),
        .wr_rdy_o      (wr_rdy),
        .wr_i          (wr),
        .host_vld_i    (host_vld_i),
        .host_i        (host_i),
        .host_rd_vld_o (host_rd_vld_o),
        .host_rd_o     (host_rd_o)
    );

endmodule

`default_nettype wire

//--- hdl/cfg_issuer.sv
// Configuration issuer
// Host start strobe captures the job record and raises a held request
// done_o pulses once the engine returns to idle after a completed job
`timescale 1ns/1ps
`default_nettype none

module cfg_issuer (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                start_i,
    input  cfg_pkg::add_cfg_t  cfg_i,
    output logic               cfg_vld_o,
    input  wire                cfg_rdy_i,
    output cfg_pkg::add_cfg_t  cfg_o,
    output logic               busy_o,
    output logic               done_o
);

    logic running;
    logic rdy_q;
    logic rdy_rise;

    // Engine back in idle
    assign rdy_rise = cfg_rdy_i && !rdy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_vld_o <= 1'b0;
            running   <= 1'b0;
            rdy_q     <= 1'b1;
            done_o    <= 1'b0;
        end else begin
            rdy_q  <= cfg_rdy_i;
            // Pending request hides the finish of an abandoned job
            done_o <= rdy_rise && running && !cfg_vld_o;
            if (start_i) cfg_vld_o <= 1'b1;
            else if (cfg_rdy_i) cfg_vld_o <= 1'b0;
            if (cfg_vld_o && cfg_rdy_i) running <= 1'b1;
            else if (rdy_rise && !cfg_vld_o) running <= 1'b0;
        end
    end

    // Record captured on the strobe
    always_ff @(posedge clk) begin
        if (start_i) cfg_o <= cfg_i;
    end

    assign busy_o = running || cfg_vld_o;

    // Record steady while offered
    a_cfg_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_vld_o && !cfg_rdy_i |=> $stable(cfg_o)
    );

endmodule

`default_nettype wire

//--- hdl/cfg_pkg.sv
// Configuration and control types for the element add engine
// The issuer and the engine share the job record and the engine state encoding
`default_nettype none

`include "eltwise_params.svh"

package cfg_pkg;

    // ======================================================================
    // Job record handed from the issuer to the engine
    // ======================================================================
    typedef struct packed {
        // Operand A region base, bank 0
        logic [`ADD_ADDR_W-1:0] a_base;
        // Operand B region base, bank 1
        logic [`ADD_ADDR_W-1:0] b_base;
        // Sum region base, bank 0
        logic [`ADD_ADDR_W-1:0] sum_base;
        // Number of words in the job
        logic [`ADD_ADDR_W-1:0] count;
    } add_cfg_t;

    // Engine FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        COMP  = 2'd1,
        DRAIN = 2'd2
    } add_state_e;

endpackage

`default_nettype wire

//--- hdl/chan_add.sv
// Channel-wise element add engine
// Takes a job record, reads paired operand words from two buffer channels,
// adds them lane by lane with 16-bit wrap and writes the sums back
// Three stages: s0 issue, s1 operand join, s2 registered sum write
`timescale 1ns/1ps
`default_nettype none

`include "eltwise_params.svh"

module chan_add (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cfg_vld_i,
    output logic                 cfg_rdy_o,
    input  cfg_pkg::add_cfg_t    cfg_i,
    output logic                 a_req_vld_o,
    input  wire                  a_req_rdy_i,
    output glb_pkg::rd_req_t     a_req_o,
    input  wire                  a_rsp_vld_i,
    output logic                 a_rsp_rdy_o,
    input  glb_pkg::glb_word_t   a_rsp_i,
    output logic                 b_req_vld_o,
    input  wire                  b_req_rdy_i,
    output glb_pkg::rd_req_t     b_req_o,
    input  wire                  b_rsp_vld_i,
    output logic                 b_rsp_rdy_o,
    input  glb_pkg::glb_word_t   b_rsp_i,
    output logic                 wr_vld_o,
    input  wire                  wr_rdy_i,
    output glb_pkg::wr_req_t     wr_o
);

    cfg_pkg::add_state_e    state;
    cfg_pkg::add_state_e    next_state;
    cfg_pkg::add_cfg_t      cfg_q;
    logic                   abandon;
    logic                   flush;
    logic                   vld_s0;
    logic                   hs0;
    logic                   both_rsp;
    logic                   take_rsp;
    logic                   hs1;
    logic                   ena_s2;
    logic                   hs2;
    logic [`ADD_ADDR_W-1:0] idx;
    logic                   idx_last;
    logic [`ADD_ADDR_W-1:0] idx_s1;
    logic                   last_s1;
    logic [`ADD_ADDR_W-1:0] idx_s2;
    logic                   last_s2;
    logic                   vld_s2;
    glb_pkg::glb_word_t     sum_s2;

    // ======================================================================
    // Control FSM
    // ======================================================================
    // New request while busy drops the running job
    assign abandon   = cfg_vld_i && (state != cfg_pkg::IDLE);
    assign cfg_rdy_o = (state == cfg_pkg::IDLE);

    always_comb begin
        next_state = state;
        case (state)
            cfg_pkg::IDLE: begin
                if (cfg_vld_i) next_state = cfg_pkg::COMP;
            end
            cfg_pkg::COMP: begin
                if (abandon) next_state = cfg_pkg::IDLE;
                else if (hs0 && idx_last) next_state = cfg_pkg::DRAIN;
            end
            cfg_pkg::DRAIN: begin
                if (abandon) next_state = cfg_pkg::IDLE;
                else if (hs2 && last_s2) next_state = cfg_pkg::IDLE;
            end
            default: next_state = cfg_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cfg_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Job record held for the whole job
    always_ff @(posedge clk) begin
        if (cfg_vld_i && cfg_rdy_o) cfg_q <= cfg_i;
    end

    // ======================================================================
    // s0 address issue
    // ======================================================================
    assign vld_s0 = (state == cfg_pkg::COMP) && !abandon;
    assign hs0    = vld_s0 && a_req_rdy_i && b_req_rdy_i;

    // Each valid waits on the other ready, so both land together
    assign a_req_vld_o  = vld_s0 && b_req_rdy_i;
    assign b_req_vld_o  = vld_s0 && a_req_rdy_i;
    assign a_req_o.addr = cfg_q.a_base + idx;
    assign b_req_o.addr = cfg_q.b_base + idx;

    step_counter i_step_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_i    (state == cfg_pkg::IDLE),
        .inc_i      (hs0),
        .last_val_i (cfg_q.count - 1'b1),
        .count_o    (idx),
        .last_o     (idx_last)
    );

    // ======================================================================
    // s1 operand join
    // ======================================================================
    // Idle or abandon drains stale responses out of the buffer
    assign flush    = (state == cfg_pkg::IDLE) || abandon;
    assign both_rsp = a_rsp_vld_i && b_rsp_vld_i;
    assign take_rsp = both_rsp && (ena_s2 || flush);
    assign hs1      = take_rsp && !flush;

    assign a_rsp_rdy_o = take_rsp;
    assign b_rsp_rdy_o = take_rsp;

    // Index follows its address, consumed in the same edge a new one lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_s1  <= '0;
            last_s1 <= 1'b0;
        end else if (hs0) begin
            idx_s1  <= idx;
            last_s1 <= idx_last;
        end
    end

    // ======================================================================
    // s2 sum and write
    // ======================================================================
    assign ena_s2 = !vld_s2 || wr_rdy_i;
    assign hs2    = vld_s2 && wr_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s2  <= 1'b0;
            last_s2 <= 1'b0;
            idx_s2  <= '0;
        end else if (flush) begin
            vld_s2  <= 1'b0;
            last_s2 <= 1'b0;
        end else if (ena_s2) begin
            vld_s2  <= hs1;
            last_s2 <= last_s1;
            idx_s2  <= idx_s1;
        end
    end

    // Lane sums wrap, no carry crosses a lane
    always_ff @(posedge clk) begin
        if (hs1) begin
            for (int i = 0; i < `ADD_LANES; i++) begin
                sum_s2[i] <= a_rsp_i[i] + b_rsp_i[i];
            end
        end
    end

    assign wr_vld_o     = vld_s2;
    assign wr_o.addr    = cfg_q.sum_base + idx_s2;
    assign wr_o.data    = sum_s2;

    // Write held steady until taken, unless the job is dropped
    a_wr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_vld_o && !wr_rdy_i && !abandon |=> wr_vld_o && $stable(wr_o)
    );

    // Operand addresses accepted as a pair, so their responses stay in step
    a_rsp_paired: assert property (
        @(posedge clk) disable iff (!rst_n)
        a_rsp_vld_i == b_rsp_vld_i
    );

endmodule

`default_nettype wire

//--- hdl/eltwise_params.svh
// Sizing macros for the element add subsystem
// Include in every RTL file and testbench that sizes lanes, words or addresses
// Packages build their structs from these values
`ifndef ELTWISE_PARAMS_SVH
`define ELTWISE_PARAMS_SVH

// Width of one lane in bits
`define ADD_LANE_W 16

// Lanes packed into one buffer word
`define ADD_LANES 4

// Word address width of each buffer bank
`define ADD_ADDR_W 10

// Words per bank, matches the address width
`define GLB_DEPTH 1024

`endif

//--- hdl/glb_buffer.sv
// Two-bank global buffer
// Bank 0 holds operand A and sums, bank 1 holds operand B
// Engine reads return through a hold register, host port loads and reads back
`timescale 1ns/1ps
`default_nettype none

`include "eltwise_params.svh"

module glb_buffer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 a_req_vld_i,
    output logic                a_req_rdy_o,
    input  glb_pkg::rd_req_t    a_req_i,
    output logic                a_rsp_vld_o,
    input  wire                 a_rsp_rdy_i,
    output glb_pkg::glb_word_t  a_rsp_o,
    input  wire                 b_req_vld_i,
    output logic                b_req_rdy_o,
    input  glb_pkg::rd_req_t    b_req_i,
    output logic                b_rsp_vld_o,
    input  wire                 b_rsp_rdy_i,
    output glb_pkg::glb_word_t  b_rsp_o,
    input  wire                 wr_vld_i,
    output logic                wr_rdy_o,
    input  glb_pkg::wr_req_t    wr_i,
    input  wire                 host_vld_i,
    input  glb_pkg::host_req_t  host_i,
    output logic                host_rd_vld_o,
    output glb_pkg::glb_word_t  host_rd_o
);

    glb_pkg::glb_word_t bank0 [`GLB_DEPTH];
    glb_pkg::glb_word_t bank1 [`GLB_DEPTH];
    logic               a_hs;
    logic               b_hs;

    // Ready only while the hold register is empty
    assign a_req_rdy_o = !a_rsp_vld_o;
    assign b_req_rdy_o = !b_rsp_vld_o;
    assign a_hs        = a_req_vld_i && a_req_rdy_o;
    assign b_hs        = b_req_vld_i && b_req_rdy_o;

    // Single port, reads block the sum write
    assign wr_rdy_o = !a_hs;

    // Response valid flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_rsp_vld_o   <= 1'b0;
            b_rsp_vld_o   <= 1'b0;
            host_rd_vld_o <= 1'b0;
        end else begin
            if (a_hs) a_rsp_vld_o <= 1'b1;
            else if (a_rsp_rdy_i) a_rsp_vld_o <= 1'b0;
            if (b_hs) b_rsp_vld_o <= 1'b1;
            else if (b_rsp_rdy_i) b_rsp_vld_o <= 1'b0;
            host_rd_vld_o <= host_vld_i && !host_i.wr;
        end
    end

    // Bank 0 port, engine read first, then sum write, then host
    always_ff @(posedge clk) begin
        if (a_hs) begin
            a_rsp_o <= bank0[a_req_i.addr];
        end else if (wr_vld_i) begin
            bank0[wr_i.addr] <= wr_i.data;
        end else if (host_vld_i && !host_i.bank && host_i.wr) begin
            bank0[host_i.addr] <= host_i.data;
        end
    end

    // Bank 1 port
    always_ff @(posedge clk) begin
        if (b_hs) begin
            b_rsp_o <= bank1[b_req_i.addr];
        end else if (host_vld_i && host_i.bank && host_i.wr) begin
            bank1[host_i.addr] <= host_i.data;
        end
    end

    // Host read-back, bank picked by the request
    always_ff @(posedge clk) begin
        if (host_vld_i && !host_i.wr) begin
            host_rd_o <= host_i.bank ? bank1[host_i.addr] : bank0[host_i.addr];
        end
    end

    // Host only touches the banks while the engine is quiet
    a_host_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_vld_i |-> !(a_req_vld_i || b_req_vld_i || wr_vld_i)
    );

endmodule

`default_nettype wire

//--- hdl/glb_pkg.sv
// Global buffer traffic types
// Words, engine read and write requests, and host port requests
`default_nettype none

`include "eltwise_params.svh"

package glb_pkg;

    // One buffer word, lane 0 in the low bits
    typedef logic [`ADD_LANES-1:0][`ADD_LANE_W-1:0] glb_word_t;

    // Engine read request
    typedef struct packed {
        logic [`ADD_ADDR_W-1:0] addr;
    } rd_req_t;

    // Engine write request, address travels with its data
    typedef struct packed {
        logic [`ADD_ADDR_W-1:0] addr;
        glb_word_t              data;
    } wr_req_t;

    // Host access, steered by bank
    typedef struct packed {
        logic                   bank;
        logic                   wr;
        logic [`ADD_ADDR_W-1:0] addr;
        glb_word_t              data;
    } host_req_t;

endpackage

`default_nettype wire

//--- hdl/step_counter.sv
// Step counter for the engine issue index
// Counts up on inc_i, returns to zero on clear_i, flags the final step
`timescale 1ns/1ps
`default_nettype none

`include "eltwise_params.svh"

module step_counter (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   clear_i,
    input  wire                   inc_i,
    input  wire [`ADD_ADDR_W-1:0] last_val_i,
    output logic [`ADD_ADDR_W-1:0] count_o,
    output logic                  last_o
);

    // Clear wins over increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else if (inc_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign last_o = (count_o == last_val_i);

    // No step taken once the final index has passed
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        inc_i && !clear_i |-> count_o <= last_val_i
    );

endmodule

`default_nettype wire
